/* hw/mvuAccumulate.sv */
//******************************
// Last pipeline stage, running sum per PE row
// ACC_CLOSE emits the total and restarts from zero on the same edge
// vld_o is registered and holds across stalled cycles
//******************************
`timescale 1ns/1ps
`include "mvu_settings.svh"

module mvuAccumulate (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_i,     // Global enable, low stalls
    input  mvuPkg::mvuDot_t    dot_i,    // Row sums and op from the dot stage
    output logic               vld_o,    // High for one enabled cycle per vector
    output mvuPkg::mvuResult_t res_o     // Closed totals, held until the next close
);

    mvuPkg::mvuResult_t openSum;    // Sum of the vector in progress
    mvuPkg::mvuResult_t total;      // Open sum plus the incoming beat

    // Add the incoming beat, wrapping at the accumulator width
    always_comb begin
        for (int pe = 0; pe < `MVU_PE; pe++) begin
            total.sum[pe] = openSum.sum[pe] + dot_i.sum[pe];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            openSum <= '0;      // Next beat opens a new vector
            res_o   <= '0;
            vld_o   <= 1'b0;
        end else if (en_i) begin
            if (dot_i.op == mvuPkg::ACC_CLOSE) begin
                res_o   <= total;    // Finished vector
                openSum <= '0;       // Following beat starts fresh
                vld_o   <= 1'b1;
            end else begin
                openSum <= total;    // Keep building
                vld_o   <= 1'b0;
            end
        end
    end

endmodule

/* hw/mvuCore.sv */
//******************************
// MVU compute core, three stage pipeline
// A last beat gives vld_o and res_o 3 enabled cycles after it is taken
// Stall by dropping en_i, there is no ready signal
//******************************
`timescale 1ns/1ps

module mvuCore (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_i,     // Beat taken on each enabled edge
    input  mvuPkg::mvuBeat_t   beat_i,   // Weights, activations, last and zero
    output logic               vld_o,    // Closed vector available
    output mvuPkg::mvuResult_t res_o     // Per-row totals
);

    mvuPkg::mvuLanes_t lanes;   // Decode to dot product
    mvuPkg::mvuDot_t   dot;     // Dot product to accumulate

    // Stage 1, register and extend the beat
    mvuDecode decode (
        .clk     (clk),
        .rst     (rst),
        .en_i    (en_i),
        .beat_i  (beat_i),
        .lanes_o (lanes)
    );

    // Stage 2, row dot products
    mvuDotProduct dotProduct (
        .clk     (clk),
        .rst     (rst),
        .en_i    (en_i),
        .lanes_i (lanes),
        .dot_o   (dot)
    );

    // Stage 3, running sums and results
    mvuAccumulate accumulate (
        .clk     (clk),
        .rst     (rst),
        .en_i    (en_i),
        .dot_i   (dot),
        .vld_o   (vld_o),
        .res_o   (res_o)
    );

endmodule

/* hw/mvuDecode.sv */
//******************************
// First pipeline stage, registers each enabled beat
// Activation extension follows MVU_ACT_SIGNED, weights are always signed
// Holds its register while en_i is low
//******************************
`timescale 1ns/1ps
`include "mvu_settings.svh"

module mvuDecode (
    input  logic              clk,
    input  logic              rst,
    input  logic              en_i,      // Global enable, low stalls
    input  mvuPkg::mvuBeat_t  beat_i,    // Raw beat
    output mvuPkg::mvuLanes_t lanes_o    // Extended beat, one cycle later
);

    localparam int actPad = `MVU_EXT_WIDTH - `MVU_ACT_WIDTH;     // Fill bits per activation
    localparam int wgtPad = `MVU_EXT_WIDTH - `MVU_WEIGHT_WIDTH;  // Fill bits per weight

    mvuPkg::mvuLanes_t lanesNext;   // Decoded beat before the register

    // Lane extension and op decode
    always_comb begin
        logic actFill;    // Fill bit for the current activation lane
        logic wgtFill;    // Fill bit for the current weight lane

        actFill = 1'b0;
        wgtFill = 1'b0;

        lanesNext.op   = beat_i.last ? mvuPkg::ACC_CLOSE : mvuPkg::ACC_CONTINUE;
        lanesNext.zero = beat_i.zero;   // Travels unchanged, applied in the dot stage

        for (int ln = 0; ln < `MVU_SIMD; ln++) begin
            // Unsigned activations fill with zero
            actFill = (`MVU_ACT_SIGNED != 0) && beat_i.act[ln][`MVU_ACT_WIDTH-1];
            lanesNext.act[ln] = {{actPad{actFill}}, beat_i.act[ln]};
        end

        for (int pe = 0; pe < `MVU_PE; pe++) begin
            for (int ln = 0; ln < `MVU_SIMD; ln++) begin
                wgtFill = beat_i.weight[pe][ln][`MVU_WEIGHT_WIDTH-1];   // Weight sign
                lanesNext.weight[pe][ln] = {{wgtPad{wgtFill}}, beat_i.weight[pe][ln]};
            end
        end
    end

    // Stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            lanes_o <= '0;            // Zero beat, op is ACC_CONTINUE
        end else if (en_i) begin
            lanes_o <= lanesNext;     // Accept one beat per enabled edge
        end
    end

endmodule

/* hw/mvuDotProduct.sv */
//******************************
// Second pipeline stage, one dot product per PE row
// A zero beat registers all-zero sums but keeps its op
// Row sums are sign extended to MVU_ACCU_WIDTH before the adds
//******************************
`timescale 1ns/1ps
`include "mvu_settings.svh"

module mvuDotProduct (
    input  logic              clk,
    input  logic              rst,
    input  logic              en_i,      // Global enable, low stalls
    input  mvuPkg::mvuLanes_t lanes_i,   // Extended beat from decode
    output mvuPkg::mvuDot_t   dot_o      // Registered row sums
);

    // Lane products, PE rows by SIMD lanes
    logic signed [`MVU_PROD_WIDTH-1:0] prod [`MVU_PE][`MVU_SIMD];

    // Row sums before the register
    logic signed [`MVU_ACCU_WIDTH-1:0] rowSum [`MVU_PE];

    // One signed multiplier per weight lane
    for (genvar pe = 0; pe < `MVU_PE; pe++) begin : genPe
        for (genvar ln = 0; ln < `MVU_SIMD; ln++) begin : genLane
            // Both operands carry their sign in the extra bit
            assign prod[pe][ln] = $signed(lanes_i.weight[pe][ln]) * $signed(lanes_i.act[ln]);
        end : genLane
    end : genPe

    // Adder over the lanes of each row
    always_comb begin
        logic signed [`MVU_ACCU_WIDTH-1:0] acc;   // Partial row sum

        acc = '0;

        for (int pe = 0; pe < `MVU_PE; pe++) begin
            acc = '0;                            // Fresh sum per row
            for (int ln = 0; ln < `MVU_SIMD; ln++) begin
                acc = acc + prod[pe][ln];        // Product sign extends here
            end
            rowSum[pe] = acc;
        end
    end

    // Stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            dot_o <= '0;                         // Sums zero, op ACC_CONTINUE
        end else if (en_i) begin
            dot_o.op <= lanes_i.op;              // Op moves even on a zero beat
            for (int pe = 0; pe < `MVU_PE; pe++) begin
                // Zero beat gates the sum only
                dot_o.sum[pe] <= lanes_i.zero ? '0 : rowSum[pe];
            end
        end
    end

endmodule

/* hw/mvuPkg.sv */
//******************************
// Types shared by the MVU pipeline stages and the testbench
// Struct sizes follow the settings macros
//******************************
`include "mvu_settings.svh"

package mvuPkg;

    // What the accumulator does with a beat
    typedef enum logic {
        ACC_CONTINUE = 1'b0,   // Add into the open sum
        ACC_CLOSE    = 1'b1    // Add, then emit and restart
    } mvuAccOp_e;

    // Raw beat as it arrives at the core
    typedef struct packed {
        logic                                                  last;   // Closes the vector
        logic                                                  zero;   // Beat adds nothing
        logic [`MVU_PE-1:0][`MVU_SIMD-1:0][`MVU_WEIGHT_WIDTH-1:0] weight;
        logic [`MVU_SIMD-1:0][`MVU_ACT_WIDTH-1:0]              act;
    } mvuBeat_t;

    // Beat after lane extension
    typedef struct packed {
        mvuAccOp_e                                          op;
        logic                                               zero;
        logic [`MVU_PE-1:0][`MVU_SIMD-1:0][`MVU_EXT_WIDTH-1:0] weight; // Sign extended
        logic [`MVU_SIMD-1:0][`MVU_EXT_WIDTH-1:0]           act;    // Sign or zero extended
    } mvuLanes_t;

    // Registered row dot products
    typedef struct packed {
        mvuAccOp_e                              op;
        logic [`MVU_PE-1:0][`MVU_ACCU_WIDTH-1:0] sum;   // Two's complement per row
    } mvuDot_t;

    // Finished totals, one per PE row
    typedef struct packed {
        logic [`MVU_PE-1:0][`MVU_ACCU_WIDTH-1:0] sum;   // Two's complement per row
    } mvuResult_t;

endpackage

/* hw/mvu_settings.svh */
//******************************
// Build-time sizes of the MVU core, shared by every stage
// Extended lanes must hold the widest operand plus a sign bit
// Product width is two extended lanes, the sum wraps at MVU_ACCU_WIDTH
//******************************
`ifndef MVU_SETTINGS_SVH
`define MVU_SETTINGS_SVH

`define MVU_PE            4   // Output rows, one dot product each
`define MVU_SIMD          6   // Lanes per beat

`define MVU_ACT_WIDTH     8   // Raw activation lane
`define MVU_WEIGHT_WIDTH  8   // Raw weight lane, always signed
`define MVU_ACCU_WIDTH    24  // Running sum and result width

`define MVU_ACT_SIGNED    1   // 1 = signed activations, 0 = unsigned

`define MVU_EXT_WIDTH     9   // Lane width after sign or zero extension
`define MVU_PROD_WIDTH    18  // Width of one extended lane product

`endif

/* run.sh */
#!/bin/bash
# Build the MVU testbench with Verilator, run it, and look for the pass message
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    -f vlog.f \
    --top-module mvuTb \
    -o VmvuTb

simStatus=0
simOut=$(./obj_dir/VmvuTb 2>&1) || simStatus=$?
echo "$simOut"

if grep -qx "Everything OK" <<< "$simOut"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass (exit status $simStatus)"
    exit 1
fi

/* testbench/mvuTb.sv */
//******************************
// Testbench for mvuCore
// Idle gaps keep en_i high with zero beats, which add nothing
// Results are checked in order against a software sum
//******************************
`timescale 1ns/1ps
`include "mvu_settings.svh"

module mvuTb;

    localparam int driveDelay   = 1;     // ns after the rising edge
    localparam int vldTimeout   = 100;   // Cycles a pending result may take
    localparam int drainTimeout = 40;    // Zero beats sent to flush results

    logic               clk;
    logic               rst;
    logic               en_i;
    mvuPkg::mvuBeat_t   beat_i;
    logic               vld_o;
    mvuPkg::mvuResult_t res_o;

    int                 seed = 71733;   // Shared by every $random call
    logic               stallOn;        // Random en_i gaps before beats
    logic               enTaken;        // Last edge was an enabled, non-reset edge
    mvuPkg::mvuResult_t expQ[$];        // Closed vectors awaiting vld_o
    mvuPkg::mvuBeat_t   curBeats[$];    // Beats of the open vector

    mvuCore uut (
        .clk    (clk),
        .rst    (rst),
        .en_i   (en_i),
        .beat_i (beat_i),
        .vld_o  (vld_o),
        .res_o  (res_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;   // 20 ns period

    always @(posedge clk) enTaken <= en_i && !rst;

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    // Signed sum of row dot products over the non-zero beats
    function automatic mvuPkg::mvuResult_t expectedResult(input mvuPkg::mvuBeat_t vec[$]);
        mvuPkg::mvuResult_t res;
        int rowAcc [`MVU_PE];
        int w;
        int a;
        res = '0;
        for (int pe = 0; pe < `MVU_PE; pe++) begin
            rowAcc[pe] = 0;
        end
        foreach (vec[i]) begin
            if (!vec[i].zero) begin
                for (int pe = 0; pe < `MVU_PE; pe++) begin
                    for (int ln = 0; ln < `MVU_SIMD; ln++) begin
                        w = $signed(vec[i].weight[pe][ln]);
                        if (`MVU_ACT_SIGNED != 0) begin
                            a = $signed(vec[i].act[ln]);
                        end else begin
                            a = vec[i].act[ln];   // Zero extended
                        end
                        rowAcc[pe] += w * a;
                    end
                end
            end
        end
        for (int pe = 0; pe < `MVU_PE; pe++) begin
            res.sum[pe] = rowAcc[pe][`MVU_ACCU_WIDTH-1:0];   // Wraps like the hardware
        end
        return res;
    endfunction

    task automatic compareResult(input mvuPkg::mvuResult_t got, input mvuPkg::mvuResult_t exp);
        for (int pe = 0; pe < `MVU_PE; pe++) begin
            if (got.sum[pe] !== exp.sum[pe]) begin
                stopRun($sformatf("ERROR at %0t ns: res_o row %0d is %0d, expected %0d",
                    $time, pe, $signed(got.sum[pe]), $signed(exp.sum[pe])));
            end
        end
    endtask

    task automatic expectFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic randomBeat(output mvuPkg::mvuBeat_t b, input logic last, input logic zero);
        int r;
        b = '0;
        b.last = last;
        b.zero = zero;
        for (int pe = 0; pe < `MVU_PE; pe++) begin
            for (int ln = 0; ln < `MVU_SIMD; ln++) begin
                r = $random(seed);
                b.weight[pe][ln] = r[`MVU_WEIGHT_WIDTH-1:0];
            end
        end
        for (int ln = 0; ln < `MVU_SIMD; ln++) begin
            r = $random(seed);
            b.act[ln] = r[`MVU_ACT_WIDTH-1:0];
        end
    endtask

    // Same value in every weight lane and every activation lane
    task automatic fillBeat(output mvuPkg::mvuBeat_t b, input int wgt, input int act);
        b = '0;
        b.last = 1'b1;
        for (int ln = 0; ln < `MVU_SIMD; ln++) begin
            b.act[ln] = act[`MVU_ACT_WIDTH-1:0];
            for (int pe = 0; pe < `MVU_PE; pe++) begin
                b.weight[pe][ln] = wgt[`MVU_WEIGHT_WIDTH-1:0];
            end
        end
    endtask

    task automatic stallCycle();
        mvuPkg::mvuBeat_t junk;
        randomBeat(junk, 1'b1, 1'b0);   // Would close a vector if taken
        @(posedge clk);
        #driveDelay;
        en_i   = 1'b0;
        beat_i = junk;
    endtask

    task automatic sendBeat(input mvuPkg::mvuBeat_t b);
        int stalls;
        stalls = 0;
        if (stallOn) begin
            stalls = $random(seed) & 3;
        end
        for (int s = 0; s < stalls; s++) begin
            stallCycle();
        end
        @(posedge clk);
        #driveDelay;
        en_i   = 1'b1;
        beat_i = b;
        curBeats.push_back(b);
        if (b.last) begin
            expQ.push_back(expectedResult(curBeats));
            curBeats.delete();
        end
    endtask

    task automatic sendVector(input int len, input logic zeroMix);
        mvuPkg::mvuBeat_t b;
        logic zeroFlag;
        int r;
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            zeroFlag = zeroMix && (r[1:0] == 2'b00);   // About one beat in four
            randomBeat(b, i == len - 1, zeroFlag);
            sendBeat(b);
        end
    endtask

    // Zero beats push closed vectors out without touching the sums
    task automatic drainPipe();
        mvuPkg::mvuBeat_t zb;
        int sent;
        zb = '0;
        zb.zero = 1'b1;
        sent = 0;
        while (expQ.size() > 0) begin
            if (sent == drainTimeout) begin
                stopRun("Timed out waiting for the pipeline to return all results");
            end
            sendBeat(zb);
            sent++;
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        #driveDelay;
        rst  = 1'b1;
        en_i = 1'b0;
        expQ.delete();       // Vector still in the pipeline never closes
        repeat (2) @(posedge clk);
        #driveDelay;
        rst = 1'b0;
        curBeats.delete();   // Open vector is lost
    endtask

    // Compare process, one check per fresh valid
    initial begin : compareProc
        mvuPkg::mvuResult_t expRes;
        int waited;
        forever begin
            waited = 0;
            @(negedge clk);
            while (!(enTaken && vld_o)) begin
                if (expQ.size() > 0) begin
                    waited++;
                end else begin
                    waited = 0;
                end
                if (waited > vldTimeout) begin
                    stopRun("Timed out waiting for vld_o");
                end
                @(negedge clk);
            end
            if (expQ.size() == 0) begin
                stopRun($sformatf("ERROR at %0t ns: vld_o with no closed vector", $time));
            end
            expRes = expQ.pop_front();
            compareResult(res_o, expRes);
        end
    end

    initial begin : stimulus
        mvuPkg::mvuBeat_t b;
        int r;
        int actMax;
        int actMin;
        int wgtMin;
        rst     = 1'b1;
        en_i    = 1'b0;
        beat_i  = '0;
        stallOn = 1'b0;
        actMax  = (`MVU_ACT_SIGNED != 0) ? (1 << (`MVU_ACT_WIDTH - 1)) - 1
                                          : (1 << `MVU_ACT_WIDTH) - 1;
        actMin  = (`MVU_ACT_SIGNED != 0) ? -(1 << (`MVU_ACT_WIDTH - 1)) : 0;
        wgtMin  = -(1 << (`MVU_WEIGHT_WIDTH - 1));
        repeat (2) @(posedge clk);
        #driveDelay;
        rst = 1'b0;
        @(negedge clk);
        expectFlag(vld_o, 1'b0, "vld_o after reset");
        compareResult(res_o, '0);

        // Single-beat extremes, valid exactly 3 enabled edges later
        fillBeat(b, wgtMin, actMax);
        sendBeat(b);
        for (int k = 1; k <= 3; k++) begin
            b = '0;
            b.zero = 1'b1;
            sendBeat(b);
            @(negedge clk);
            expectFlag(vld_o, k == 3, "vld_o after single-beat vector");
        end
        fillBeat(b, wgtMin, actMin);
        sendBeat(b);
        drainPipe();

        // Random lengths back to back
        for (int v = 0; v < 20; v++) begin
            r = $random(seed);
            sendVector(1 + r[3:0], 1'b0);
        end
        drainPipe();

        // Zero beats mixed in, then a vector of zero beats only
        for (int v = 0; v < 10; v++) begin
            r = $random(seed);
            sendVector(1 + r[3:0], 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            randomBeat(b, i == 3, 1'b1);
            sendBeat(b);
        end
        drainPipe();

        // en_i gaps
        stallOn = 1'b1;
        for (int v = 0; v < 15; v++) begin
            r = $random(seed);
            sendVector(1 + r[3:0], 1'b1);
        end
        drainPipe();
        stallOn = 1'b0;

        // Reset while a vector is partly summed and its last beat is in flight
        for (int i = 0; i < 5; i++) begin
            randomBeat(b, i == 4, 1'b0);
            sendBeat(b);
        end
        resetDut();
        for (int i = 0; i < 5; i++) begin
            b = '0;
            b.zero = 1'b1;
            sendBeat(b);
            @(negedge clk);
            expectFlag(vld_o, 1'b0, "vld_o after mid-vector reset");
        end
        sendVector(5, 1'b0);
        b = '0;
        b.zero = 1'b1;
        for (int i = 0; i < 4; i++) begin
            sendBeat(b);   // Close reaches vld_o on the third of these edges
        end

        repeat (4) @(posedge clk);
        if (expQ.size() != 0) begin
            stopRun("Some expected results never arrived");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* testbench/mvu_chk.sv */
//******************************
// Port-level assertions for mvuCore, attached by bind
// Expects one valid per last beat, 3 enabled edges after it
//******************************
`timescale 1ns/1ps

module mvuChk (
    input  logic               clk,
    input  logic               rst,
    input  logic               en_i,     // Core enable
    input  mvuPkg::mvuBeat_t   beat_i,   // Core input beat
    input  logic               vld_i,    // Core vld_o
    input  mvuPkg::mvuResult_t res_i     // Core res_o
);

    logic [2:0] lastSeen;   // Last flags of the beats in the 3 stages

    always_ff @(posedge clk) begin
        if (rst) begin
            lastSeen <= '0;
        end else if (en_i) begin
            lastSeen <= {lastSeen[1:0], beat_i.last};   // Moves only on enabled edges
        end
    end

    // No valid while reset is applied or on the first edge after release
    vldLowInReset: assert property (@(posedge clk) rst |=> !vld_i)
        else $error("vld_o high after a reset edge");
    vldLowAfterReset: assert property (@(posedge clk) $fell(rst) |=> !vld_i)
        else $error("vld_o high right after reset release");

    // A stalled edge changes no result
    resHeldOnStall: assert property (@(posedge clk) disable iff (rst) !en_i |=> $stable(res_i))
        else $error("res_o changed while en_i was low");

    // Valid tracks the last flag three enabled edges back
    vldFollowsLast: assert property (@(posedge clk) disable iff (rst)
        en_i |=> (vld_i == lastSeen[2]))
        else $error("vld_o does not follow an accepted last beat");

endmodule

bind mvuCore mvuChk chk (
    .clk    (clk),
    .rst    (rst),
    .en_i   (en_i),
    .beat_i (beat_i),
    .vld_i  (vld_o),
    .res_i  (res_o)
);

/* vlog.f */
+incdir+hw
hw/mvuPkg.sv
hw/mvuDecode.sv
hw/mvuDotProduct.sv
hw/mvuAccumulate.sv
hw/mvuCore.sv
testbench/mvu_chk.sv
testbench/mvuTb.sv
